//--- common/sru_pkg.sv
//****************************************
// widths, CSR map, bit positions, enums and packed structs
// shared by the machine-mode trap unit.
//****************************************
package sru_pkg;

    // data path width and the code field of mcause.
    localparam int XLEN         = 32;
    localparam int CODE_WIDTH   = 4;
    // widest PC the trap request can carry.
    localparam int PC_MAX_WIDTH = 32;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [11:0]           csr_addr_t;
    typedef logic [CODE_WIDTH-1:0] cause_code_t;

    // machine trap setup and handling CSRs.
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // mstatus field positions. MPP names the low bit of its 2-bit field.
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

    // interrupt bits in mie and mip match their cause codes.
    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_MEI = 11;

    localparam int CAUSE_INT = 31;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } priv_t;

    typedef enum logic [1:0] {
        EV_NONE,
        EV_EXC,
        EV_IRQ,
        EV_MRET
    } event_kind_t;

    typedef struct packed {
        logic msi;
        logic mti;
        logic mei;
    } irq_bits_t;

    typedef struct packed {
        logic  mie;
        logic  mpie;
        priv_t mpp;
    } status_t;

    typedef struct packed {
        logic      wr;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_write_t;

    typedef struct packed {
        logic                    en;
        xlen_t                   cause;
        xlen_t                   val;
        logic [PC_MAX_WIDTH-1:0] epc;
    } trap_req_t;

    // what the trap controller reports to the register blocks.
    typedef struct packed {
        event_kind_t kind;
        xlen_t       cause;
        xlen_t       tval;
    } trap_event_t;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module sru_tb -f sim.f --Mdir obj_dir -o sru_sim
./obj_dir/sru_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    exit 1
fi

//--- sim.f
+incdir+verification
common/sru_pkg.sv
verilog/trap/irq_arbiter.sv
verilog/trap/trap_ctrl.sv
verilog/csr/status_regs.sv
verilog/csr/trap_regs.sv
verilog/csr/csr_read_mux.sv
verilog/sru_top.sv
verification/sru_tb.sv

//--- verification/sru_tb_tasks.svh
//****************************************
// stimulus, wait and reporting tasks of the trap unit testbench.
//****************************************
`ifndef SRU_TB_TASKS_SVH
`define SRU_TB_TASKS_SVH

function automatic void report_mismatch(string name, xlen_t got, xlen_t exp);
    $display("Mismatch %s: got %h, expected %h", name, got, exp);
    errors++;
endfunction

// architectural mstatus and mie/mip words built from the field positions.
function automatic xlen_t status_word(logic mie, logic mpie, priv_t mpp);
    return (xlen_t'(mie) << MSTATUS_MIE) | (xlen_t'(mpie) << MSTATUS_MPIE)
         | (xlen_t'(mpp) << MSTATUS_MPP);
endfunction

function automatic xlen_t irq_word(logic msi, logic mti, logic mei);
    return (xlen_t'(msi) << IRQ_MSI) | (xlen_t'(mti) << IRQ_MTI) | (xlen_t'(mei) << IRQ_MEI);
endfunction

task automatic csr_write(csr_addr_t addr, xlen_t data);
    @(posedge clk);
    csr_w <= '{wr: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    csr_w <= '0;
endtask

task automatic csr_check(csr_addr_t addr, xlen_t exp);
    @(posedge clk);
    csr_raddr <= addr;
    exp_rdata <= exp;
    chk_rdata <= 1'b1;
    @(posedge clk);
    chk_rdata <= 1'b0;
endtask

task automatic expect_prv(priv_t p);
    @(posedge clk);
    exp_prv <= p;
    chk_prv <= 1'b1;
    @(posedge clk);
    chk_prv <= 1'b0;
endtask

task automatic expect_flags(logic irq, logic wake, logic eret);
    @(posedge clk);
    exp_irq   <= irq;
    exp_wake  <= wake;
    exp_eret  <= eret;
    chk_flags <= 1'b1;
    @(posedge clk);
    chk_flags <= 1'b0;
endtask

task automatic set_lines(logic msi, logic mti, logic mei);
    @(posedge clk);
    ext_msip <= msi;
    ext_mtip <= mti;
    ext_meip <= mei;
endtask

task automatic raise_exception(xlen_t c, xlen_t v, xlen_t epc, xlen_t vec);
    @(posedge clk);
    trap      <= '{en: 1'b1, cause: c, val: v, epc: epc};
    exp_cause <= c;
    exp_tval  <= v;
    exp_vec   <= vec;
    chk_trap  <= 1'b1;
    @(posedge clk);
    trap     <= '0;
    chk_trap <= 1'b0;
endtask

task automatic send_mret(xlen_t epc);
    @(posedge clk);
    mret      <= 1'b1;
    exp_irq   <= 1'b0;
    exp_wake  <= 1'b0;
    exp_eret  <= 1'b1;
    exp_epc   <= epc;
    chk_flags <= 1'b1;
    chk_ret   <= 1'b1;
    @(posedge clk);
    mret      <= 1'b0;
    chk_flags <= 1'b0;
    chk_ret   <= 1'b0;
endtask

// vectored target is the base plus four times the code.
task automatic arm_irq_check(cause_code_t code, xlen_t base);
    @(posedge clk);
    exp_cause <= (xlen_t'(1) << CAUSE_INT) | xlen_t'(code);
    exp_tval  <= '0;
    exp_vec   <= base + (xlen_t'(code) << 2);
    chk_trap  <= 1'b1;
endtask

task automatic disarm_irq_check();
    @(posedge clk);
    chk_trap <= 1'b0;
endtask

task automatic wait_irq(string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq_trigger && n < TIMEOUT_CYCLES) begin
        @(negedge clk);
        n++;
    end
    if (!irq_trigger) begin
        $display("timeout: irq_trigger never rose for the %s", what);
        errors++;
    end
endtask

task automatic wait_mip(xlen_t exp);
    int n;
    n = 0;
    @(posedge clk);
    csr_raddr <= CSR_MIP;
    @(negedge clk);
    while (csr_rdata != exp && n < TIMEOUT_CYCLES) begin
        @(negedge clk);
        n++;
    end
    if (csr_rdata != exp) begin
        $display("timeout: mip did not reach %h", exp);
        errors++;
    end
endtask

task automatic finish_test(string name);
    @(negedge clk);
    tests_run++;
    if (errors != errors_at_start) begin
        tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end else begin
        $display("test %0d %s: passed", tests_run, name);
    end
    errors_at_start = errors;
endtask

`endif

//--- verification/sru_tb.sv
//****************************************
// testbench top for the trap unit with clock, reset, DUT and checks.
//****************************************
`timescale 1ns/1ps

module sru_tb import sru_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20;

    logic       clk;
    logic       rstn;
    trap_req_t  trap;
    logic       mret;
    csr_write_t csr_w;
    csr_addr_t  csr_raddr;
    logic       ext_msip;
    logic       ext_mtip;
    logic       ext_meip;
    priv_t      prv;
    logic       wakeup;
    logic       irq_trigger;
    logic       eret_en;
    xlen_t      cause;
    xlen_t      tval;
    xlen_t      trap_vec;
    xlen_t      ret_epc;
    xlen_t      csr_rdata;

    // check enables and the values the checks expect.
    logic  chk_rdata;
    logic  chk_prv;
    logic  chk_flags;
    logic  chk_trap;
    logic  chk_ret;
    xlen_t exp_rdata;
    xlen_t exp_cause;
    xlen_t exp_tval;
    xlen_t exp_vec;
    xlen_t exp_epc;
    priv_t exp_prv;
    logic  exp_irq;
    logic  exp_wake;
    logic  exp_eret;

    int        seed;
    int        errors;
    int        errors_at_start;
    int        tests_run;
    int        tests_failed;
    xlen_t     rnd;
    xlen_t     mtvec_val;
    xlen_t     vec_base;
    xlen_t     mepc_val;
    xlen_t     exc_cause;
    xlen_t     exc_val;
    xlen_t     exc_epc;
    logic      mpie_bit;
    csr_addr_t csr_list [8];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    sru_top dut_i (.*);

    `include "sru_tb_tasks.svh"

    rdata_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_rdata |-> csr_rdata == exp_rdata)
        else report_mismatch("csr_rdata", $sampled(csr_rdata), $sampled(exp_rdata));
    prv_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_prv |-> prv == exp_prv)
        else report_mismatch("prv", $sampled(prv), $sampled(exp_prv));
    irq_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_flags |-> irq_trigger == exp_irq)
        else report_mismatch("irq_trigger", $sampled(irq_trigger), $sampled(exp_irq));
    wake_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_flags |-> wakeup == exp_wake)
        else report_mismatch("wakeup", $sampled(wakeup), $sampled(exp_wake));
    eret_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_flags |-> eret_en == exp_eret)
        else report_mismatch("eret_en", $sampled(eret_en), $sampled(exp_eret));
    ret_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_ret |-> ret_epc == exp_epc)
        else report_mismatch("ret_epc", $sampled(ret_epc), $sampled(exp_epc));

    // trap outputs only matter in a cycle that takes a trap.
    cause_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_trap && (trap.en || irq_trigger) |-> cause == exp_cause)
        else report_mismatch("cause", $sampled(cause), $sampled(exp_cause));
    tval_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_trap && (trap.en || irq_trigger) |-> tval == exp_tval)
        else report_mismatch("tval", $sampled(tval), $sampled(exp_tval));
    vec_check: assert property (@(posedge clk) disable iff (!rstn)
        chk_trap && (trap.en || irq_trigger) |-> trap_vec == exp_vec)
        else report_mismatch("trap_vec", $sampled(trap_vec), $sampled(exp_vec));

    initial begin
        seed = 94;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        rstn = 1'b0;
        trap = '0;
        mret = 1'b0;
        csr_w = '0;
        csr_raddr = '0;
        ext_msip = 1'b0;
        ext_mtip = 1'b0;
        ext_meip = 1'b0;
        {chk_rdata, chk_prv, chk_flags, chk_trap, chk_ret} = '0;
        {exp_rdata, exp_cause, exp_tval, exp_vec, exp_epc} = '0;
        {exp_irq, exp_wake, exp_eret} = '0;
        exp_prv = PRV_M;
        csr_list = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                     CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP};
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        expect_prv(PRV_M);
        expect_flags(1'b0, 1'b0, 1'b0);
        foreach (csr_list[i]) csr_check(csr_list[i], '0);
        finish_test("reset state");

        rnd = $random(seed);
        csr_write(CSR_MSCRATCH, rnd);
        csr_check(CSR_MSCRATCH, rnd);
        rnd = $random(seed);
        csr_write(CSR_MCAUSE, rnd);
        csr_check(CSR_MCAUSE, rnd);
        rnd = $random(seed);
        csr_write(CSR_MTVAL, rnd);
        csr_check(CSR_MTVAL, rnd);
        rnd = $random(seed) | 32'h2;
        csr_write(CSR_MTVEC, rnd);
        csr_check(CSR_MTVEC, rnd & ~32'h2);
        rnd = $random(seed) | 32'h1;
        csr_write(CSR_MEPC, rnd);
        csr_check(CSR_MEPC, rnd & ~32'h1);
        finish_test("csr write and read");

        // exceptions go to the base even in vectored mode.
        mtvec_val = ($random(seed) & ~32'h3) | 32'h1;
        vec_base  = mtvec_val & ~32'h3;
        csr_write(CSR_MTVEC, mtvec_val);
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0, PRV_U));
        exc_cause = $random(seed) & 32'hf;
        exc_val   = $random(seed);
        exc_epc   = $random(seed);
        raise_exception(exc_cause, exc_val, exc_epc, vec_base);
        csr_check(CSR_MEPC, exc_epc);
        csr_check(CSR_MCAUSE, exc_cause);
        csr_check(CSR_MTVAL, exc_val);
        csr_check(CSR_MSTATUS, status_word(1'b0, 1'b1, PRV_M));
        expect_prv(PRV_M);
        finish_test("exception entry");

        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0, PRV_M));
        csr_write(CSR_MIE, irq_word(1'b1, 1'b1, 1'b1));
        arm_irq_check(cause_code_t'(IRQ_MTI), vec_base);
        set_lines(1'b0, 1'b1, 1'b0);
        wait_irq("timer line");
        disarm_irq_check();
        csr_check(CSR_MCAUSE, (xlen_t'(1) << CAUSE_INT) | xlen_t'(IRQ_MTI));
        // MIE is now clear but the enabled timer still wakes the core.
        expect_flags(1'b0, 1'b1, 1'b0);
        set_lines(1'b1, 1'b1, 1'b1);
        wait_mip(irq_word(1'b1, 1'b1, 1'b1));
        arm_irq_check(cause_code_t'(IRQ_MEI), vec_base);
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0, PRV_M));
        wait_irq("all three lines");
        disarm_irq_check();
        finish_test("interrupt entry and priority");

        set_lines(1'b0, 1'b0, 1'b0);
        csr_write(CSR_MIE, '0);
        mepc_val = $random(seed) & ~32'h1;
        csr_write(CSR_MEPC, mepc_val);
        rnd = $random(seed);
        mpie_bit = rnd[0];
        csr_write(CSR_MSTATUS, status_word(1'b0, mpie_bit, PRV_U));
        send_mret(mepc_val);
        expect_prv(PRV_U);
        csr_check(CSR_MSTATUS, status_word(mpie_bit, 1'b1, PRV_U));
        finish_test("mret");

        // in user mode only the per-source enables gate interrupts.
        csr_write(CSR_MSTATUS, status_word(1'b0, 1'b0, PRV_U));
        csr_write(CSR_MIE, irq_word(1'b0, 1'b1, 1'b0));
        set_lines(1'b1, 1'b0, 1'b0);
        wait_mip(irq_word(1'b1, 1'b0, 1'b0));
        expect_flags(1'b0, 1'b0, 1'b0);
        arm_irq_check(cause_code_t'(IRQ_MTI), vec_base);
        set_lines(1'b1, 1'b1, 1'b0);
        wait_irq("user mode timer");
        disarm_irq_check();
        expect_prv(PRV_M);
        set_lines(1'b0, 1'b0, 1'b0);
        finish_test("user mode");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/csr/csr_read_mux.sv
//****************************************
// CSR read decode with architectural field layout.
//****************************************
`timescale 1ns/1ps

module csr_read_mux import sru_pkg::*; (
    input  csr_addr_t csr_raddr,
    input  status_t   status,
    input  irq_bits_t enables,
    input  irq_bits_t pending,
    input  xlen_t     mtvec,
    input  xlen_t     mscratch,
    input  xlen_t     mepc,
    input  xlen_t     mcause,
    input  xlen_t     mtval,
    output xlen_t     csr_rdata
);

    // mie and mip share the same bit layout.
    function automatic xlen_t irq_layout(irq_bits_t bits);
        xlen_t word;
        word          = '0;
        word[IRQ_MSI] = bits.msi;
        word[IRQ_MTI] = bits.mti;
        word[IRQ_MEI] = bits.mei;
        return word;
    endfunction

    always_comb begin
        csr_rdata = '0;
        case (csr_raddr)
            CSR_MSTATUS: begin
                csr_rdata[MSTATUS_MIE]      = status.mie;
                csr_rdata[MSTATUS_MPIE]     = status.mpie;
                csr_rdata[MSTATUS_MPP +: 2] = status.mpp;
            end
            CSR_MIE:      csr_rdata = irq_layout(enables);
            CSR_MIP:      csr_rdata = irq_layout(pending);
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MTVAL:    csr_rdata = mtval;
            default:      csr_rdata = '0;
        endcase
    end

endmodule

//--- verilog/csr/status_regs.sv
//****************************************
// mstatus fields and mie enables.
//****************************************
`timescale 1ns/1ps

module status_regs import sru_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  csr_write_t  csr_w,
    input  trap_event_t evt,
    input  priv_t       prv,
    output status_t     status,
    output irq_bits_t   enables
);

    logic  wr_mstatus;
    logic  wr_mie;
    priv_t wr_mpp;

    assign wr_mstatus = csr_w.wr && csr_w.addr == CSR_MSTATUS;
    assign wr_mie     = csr_w.wr && csr_w.addr == CSR_MIE;

    // only M and U exist, so anything else falls back to U.
    assign wr_mpp = (csr_w.wdata[MSTATUS_MPP +: 2] == PRV_M) ? PRV_M : PRV_U;

    // a trap or mret wins over a write in the same cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            status <= '0;
        end else if (evt.kind == EV_EXC || evt.kind == EV_IRQ) begin
            status.mpp  <= prv;
            status.mpie <= status.mie;
            status.mie  <= 1'b0;
        end else if (evt.kind == EV_MRET) begin
            status.mie  <= status.mpie;
            status.mpie <= 1'b1;
            status.mpp  <= PRV_U;
        end else if (wr_mstatus) begin
            status.mie  <= csr_w.wdata[MSTATUS_MIE];
            status.mpie <= csr_w.wdata[MSTATUS_MPIE];
            status.mpp  <= wr_mpp;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            enables <= '0;
        end else if (wr_mie) begin
            enables.msi <= csr_w.wdata[IRQ_MSI];
            enables.mti <= csr_w.wdata[IRQ_MTI];
            enables.mei <= csr_w.wdata[IRQ_MEI];
        end
    end

endmodule

//--- verilog/csr/trap_regs.sv
//****************************************
// mtvec, mscratch, mepc, mcause and mtval.
//****************************************
`timescale 1ns/1ps

module trap_regs import sru_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_write_t          csr_w,
    input  trap_event_t         evt,
    input  logic [PC_WIDTH-1:0] epc,
    output xlen_t               mtvec,
    output xlen_t               mscratch,
    output xlen_t               mepc,
    output xlen_t               mcause,
    output xlen_t               mtval
);

    logic                trap_taken;
    logic [PC_WIDTH-1:0] mepc_q;

    assign trap_taken = evt.kind == EV_EXC || evt.kind == EV_IRQ;

    // bit 1 is reserved since only direct and vectored modes exist.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtvec <= '0;
        end else if (csr_w.wr && csr_w.addr == CSR_MTVEC) begin
            mtvec <= csr_w.wdata & ~xlen_t'(2);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mscratch <= '0;
        end else if (csr_w.wr && csr_w.addr == CSR_MSCRATCH) begin
            mscratch <= csr_w.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc_q <= '0;
        end else if (trap_taken) begin
            mepc_q <= epc;
        end else if (csr_w.wr && csr_w.addr == CSR_MEPC) begin
            mepc_q <= csr_w.wdata[PC_WIDTH-1:0] & ~PC_WIDTH'(1);
        end
    end

    // narrow PCs read back zero-extended.
    assign mepc = xlen_t'(mepc_q);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mcause <= '0;
        end else if (trap_taken) begin
            mcause <= evt.cause;
        end else if (csr_w.wr && csr_w.addr == CSR_MCAUSE) begin
            mcause <= csr_w.wdata;
        end
    end

    // interrupts carry a zero tval.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtval <= '0;
        end else if (trap_taken) begin
            mtval <= evt.tval;
        end else if (csr_w.wr && csr_w.addr == CSR_MTVAL) begin
            mtval <= csr_w.wdata;
        end
    end

    irq_tval_zero: assert property (@(posedge clk) disable iff (!rstn)
        evt.kind == EV_IRQ |-> evt.tval == '0)
        else $error("interrupt event carries tval %h", evt.tval);

endmodule

//--- verilog/sru_top.sv
//****************************************
// top level of the machine-mode trap unit.
//****************************************
`timescale 1ns/1ps

module sru_top import sru_pkg::*; #(
    parameter int PC_WIDTH    = 32,
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                rstn,
    // core side.
    input  trap_req_t           trap,
    input  logic                mret,
    input  csr_write_t          csr_w,
    input  csr_addr_t           csr_raddr,
    // interrupt controller side.
    input  logic                ext_msip,
    input  logic                ext_mtip,
    input  logic                ext_meip,
    output priv_t               prv,
    output logic                wakeup,
    output logic                irq_trigger,
    output logic                eret_en,
    output xlen_t               cause,
    output xlen_t               tval,
    output logic [PC_WIDTH-1:0] trap_vec,
    output logic [PC_WIDTH-1:0] ret_epc,
    output xlen_t               csr_rdata
);

    irq_bits_t   pending;
    irq_bits_t   enables;
    logic        irq_valid;
    cause_code_t irq_code;
    trap_event_t evt;
    status_t     status;
    xlen_t       mtvec;
    xlen_t       mscratch;
    xlen_t       mepc;
    xlen_t       mcause;
    xlen_t       mtval;

    irq_arbiter #(.SYNC_STAGES(SYNC_STAGES)) irq_arbiter_i (
        .clk       (clk),
        .rstn      (rstn),
        .ext_msip  (ext_msip),
        .ext_mtip  (ext_mtip),
        .ext_meip  (ext_meip),
        .enables   (enables),
        .pending   (pending),
        .irq_valid (irq_valid),
        .irq_code  (irq_code),
        .wakeup    (wakeup)
    );

    trap_ctrl #(.PC_WIDTH(PC_WIDTH)) trap_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .trap        (trap),
        .mret        (mret),
        .irq_valid   (irq_valid),
        .irq_code    (irq_code),
        .status      (status),
        .mtvec       (mtvec),
        .mepc        (mepc[PC_WIDTH-1:0]),
        .prv         (prv),
        .evt         (evt),
        .irq_trigger (irq_trigger),
        .eret_en     (eret_en),
        .cause       (cause),
        .tval        (tval),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc)
    );

    status_regs status_regs_i (
        .clk     (clk),
        .rstn    (rstn),
        .csr_w   (csr_w),
        .evt     (evt),
        .prv     (prv),
        .status  (status),
        .enables (enables)
    );

    trap_regs #(.PC_WIDTH(PC_WIDTH)) trap_regs_i (
        .clk      (clk),
        .rstn     (rstn),
        .csr_w    (csr_w),
        .evt      (evt),
        .epc      (trap.epc[PC_WIDTH-1:0]),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval)
    );

    csr_read_mux csr_read_mux_i (
        .csr_raddr (csr_raddr),
        .status    (status),
        .enables   (enables),
        .pending   (pending),
        .mtvec     (mtvec),
        .mscratch  (mscratch),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .csr_rdata (csr_rdata)
    );

endmodule

//--- verilog/trap/irq_arbiter.sv
//****************************************
// interrupt synchronizer, pending bits and priority pick.
//****************************************
`timescale 1ns/1ps

module irq_arbiter import sru_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        ext_msip,
    input  logic        ext_mtip,
    input  logic        ext_meip,
    input  irq_bits_t   enables,
    output irq_bits_t   pending,
    output logic        irq_valid,
    output cause_code_t irq_code,
    output logic        wakeup
);

    irq_bits_t [SYNC_STAGES-1:0] sync_q;
    irq_bits_t                   active;

    // the last stage of the chain is the mip view.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= '{msi: ext_msip, mti: ext_mtip, mei: ext_meip};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pending = sync_q[SYNC_STAGES-1];
    assign active  = pending & enables;

    // wakes the core even with the global enable off.
    assign wakeup    = |active;
    assign irq_valid = |active;

    // external wins over software, software over timer.
    always_comb begin
        if (active.mei) begin
            irq_code = cause_code_t'(IRQ_MEI);
        end else if (active.msi) begin
            irq_code = cause_code_t'(IRQ_MSI);
        end else if (active.mti) begin
            irq_code = cause_code_t'(IRQ_MTI);
        end else begin
            irq_code = '0;
        end
    end

endmodule

//--- verilog/trap/trap_ctrl.sv
//****************************************
// privilege level, trap decision, vector and cause.
//****************************************
`timescale 1ns/1ps

module trap_ctrl import sru_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  trap_req_t           trap,
    input  logic                mret,
    input  logic                irq_valid,
    input  cause_code_t         irq_code,
    input  status_t             status,
    input  xlen_t               mtvec,
    input  logic [PC_WIDTH-1:0] mepc,
    output priv_t               prv,
    output trap_event_t         evt,
    output logic                irq_trigger,
    output logic                eret_en,
    output xlen_t               cause,
    output xlen_t               tval,
    output logic [PC_WIDTH-1:0] trap_vec,
    output logic [PC_WIDTH-1:0] ret_epc
);

    logic                irq_allowed;
    xlen_t               irq_cause;
    logic [PC_WIDTH-1:0] vec_base;
    logic [PC_WIDTH-1:0] vec_offset;

    // user mode always takes enabled interrupts.
    assign irq_allowed = (prv == PRV_U) || (prv == PRV_M && status.mie);

    // exception first, then interrupt, then mret.
    assign irq_trigger = !trap.en && irq_valid && irq_allowed;
    assign eret_en     = !trap.en && !irq_trigger && mret;

    always_comb begin
        irq_cause            = xlen_t'(irq_code);
        irq_cause[CAUSE_INT] = 1'b1;
    end

    assign cause = trap.en     ? trap.cause :
                   irq_trigger ? irq_cause  : '0;
    assign tval  = trap.en ? trap.val : '0;

    // vectored mode only applies to interrupts.
    assign vec_base   = mtvec[PC_WIDTH-1:0] & ~PC_WIDTH'(3);
    assign vec_offset = (irq_trigger && mtvec[0]) ? PC_WIDTH'({irq_code, 2'b00}) : '0;
    assign trap_vec   = vec_base + vec_offset;
    assign ret_epc    = mepc;

    always_comb begin
        if (trap.en) begin
            evt.kind = EV_EXC;
        end else if (irq_trigger) begin
            evt.kind = EV_IRQ;
        end else if (eret_en) begin
            evt.kind = EV_MRET;
        end else begin
            evt.kind = EV_NONE;
        end
        evt.cause = cause;
        evt.tval  = tval;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prv <= PRV_M;
        end else if (evt.kind == EV_EXC || evt.kind == EV_IRQ) begin
            prv <= PRV_M;
        end else if (evt.kind == EV_MRET) begin
            prv <= status.mpp;
        end
    end

    // a taken interrupt enters M mode with MIE cleared, so the request drops.
    irq_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
        irq_trigger |=> !irq_trigger)
        else $error("irq_trigger stayed high after the interrupt was taken");

endmodule
